/* include/decode_consts.svh */
// Decode stage constants
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Opcodes
`define OP_ADD		6'b00_0000
`define OP_SUB		6'b00_0001
`define OP_LHW		6'b00_0010
`define OP_LLW		6'b00_0011
`define OP_AND		6'b00_0100
`define OP_OR		6'b00_0101
`define OP_XOR		6'b00_0110
`define OP_NOT		6'b00_0111
`define OP_SLL		6'b00_1000
`define OP_SRL		6'b00_1001
`define OP_SRA		6'b00_1010
`define OP_FLUSH	6'b00_1100
`define OP_BRANCH	6'b01_0000
`define OP_CALL		6'b01_0001
`define OP_RET		6'b01_0010
`define OP_LOAD		6'b01_0100
`define OP_STORE	6'b01_0101
`define OP_MULT		6'b01_0110
`define OP_DIV		6'b01_0111
`define OP_FADD		6'b01_1000
`define OP_FSUB		6'b01_1001
`define OP_FMULT	6'b01_1010
`define OP_FDIV		6'b01_1011
`define OP_FTOI		6'b01_1100
`define OP_ITOF		6'b01_1101
`define OP_SQRT		6'b01_1110
`define OP_HALT		6'b01_1111
`define OP_ENQC		6'b10_0000
`define OP_ENQD		6'b10_0100
`define OP_DEQD		6'b10_0101

// Register file and bus widths
`define REG_COUNT	32
`define REG_ADDR_W	5
`define DATA_W		32
`define INSTR_W		32
`define OFFSET_W	26
`define SHIFT_W		5

// Implicit destination and source of CALL and RET
`define LINK_REG	5'd1

// Address arithmetic for memory and call instructions
`define ALU_ADD		4'b0000

`endif

/* hw/decodePkg.sv */
// Decode stage types
package decodePkg;

	`include "decode_consts.svh"

	// Register form of the instruction word
	typedef struct packed {
		logic [5:0]				opcode;
		logic [`REG_ADDR_W-1:0]	rd;
		logic [`REG_ADDR_W-1:0]	rs1;
		logic [`REG_ADDR_W-1:0]	rs2;
		logic [5:0]				unused;
		logic [`SHIFT_W-1:0]	shamt;
	} regView;

	// Branch form, the offset covers cond and offsetLow
	typedef struct packed {
		logic [5:0]		opcode;
		logic [2:0]		cond;
		logic [22:0]	offsetLow;
	} branchView;

	typedef union packed {
		regView		r;
		branchView	b;
	} instrWord;

	typedef enum logic [1:0] {
		EXU_ALU	= 2'b00,
		EXU_MDU	= 2'b01,
		EXU_FPU	= 2'b10
	} exuSel;

	typedef enum logic [2:0] {
		B_NEQ, B_EQ, B_GT, B_LT, B_GTE, B_LTE, B_OVFL, B_UNCON
	} branchCond;

endpackage

/* hw/instrDecoder.sv */
// Instruction decoder
`timescale 1ns/1ns
`include "decode_consts.svh"

module instrDecoder (
	input	decodePkg::instrWord		instr,
	output	logic [`REG_ADDR_W-1:0]		readAddr0,
	output	logic						readEn0,
	output	logic [`REG_ADDR_W-1:0]		readAddr1,
	output	logic						readEn1,
	output	logic [`REG_ADDR_W-1:0]		writeAddr,
	output	logic						writeEn,
	output	decodePkg::exuSel			exu,
	output	logic [3:0]					aluOp,
	output	logic [2:0]					fpuOp,
	output	logic						mduOp,
	output	decodePkg::branchCond		branchOp,
	output	logic [`SHIFT_W-1:0]		shiftAmt,
	output	logic [`OFFSET_W-1:0]		offset,
	output	logic						memValid,
	output	logic						memWrite,
	output	logic						memToReg,
	output	logic						flagEn,
	output	logic						branchCmd,
	output	logic						jumpCmd,
	output	logic						callCmd,
	output	logic						retCmd,
	output	logic						loadCmd,
	output	logic						storeCmd,
	output	logic						aluCmd,
	output	logic						cacheFlush,
	output	logic						halt,
	output	logic						npuCfg,
	output	logic						npuEnq,
	output	logic						npuDeq
);

	logic [5:0]	op;
	logic		isLink;
	logic		isMem;
	logic		isShift;
	logic		isFpu;
	logic		isMdu;

	assign op		= instr.r.opcode;
	assign isLink	= (op == `OP_CALL) || (op == `OP_RET);
	assign isMem	= (op == `OP_LOAD) || (op == `OP_STORE);
	assign isShift	= (op == `OP_SLL) || (op == `OP_SRL) || (op == `OP_SRA);
	assign isFpu	= (op >= `OP_FADD) && (op <= `OP_SQRT);
	assign isMdu	= (op == `OP_MULT) || (op == `OP_DIV);

	// Destination
	assign writeEn		= !((op == `OP_FLUSH) || (op == `OP_BRANCH) || (op == `OP_STORE) ||
							(op == `OP_HALT) || (op == `OP_ENQC) || (op == `OP_ENQD));
	assign writeAddr	= isLink ? `LINK_REG : instr.r.rd;

	// LHW and ENQD read their own destination field
	assign readEn0		= !((op == `OP_LLW) || (op == `OP_FLUSH) || (op == `OP_BRANCH) ||
							(op == `OP_HALT) || (op == `OP_ENQC) || (op == `OP_DEQD));
	assign readAddr0	= ((op == `OP_LHW) || (op == `OP_ENQD)) ? instr.r.rd :
							(isLink ? `LINK_REG : instr.r.rs1);

	// Store data goes through port 1
	assign readEn1		= !((op == `OP_LHW) || (op == `OP_LLW) || (op == `OP_NOT) || isShift ||
							(op == `OP_FLUSH) || (op == `OP_BRANCH) || (op == `OP_CALL) ||
							(op == `OP_FTOI) || (op == `OP_ITOF) || (op == `OP_SQRT) ||
							(op == `OP_HALT) || (op == `OP_ENQC) || (op == `OP_ENQD) ||
							(op == `OP_DEQD));
	assign readAddr1	= (op == `OP_STORE) ? instr.r.rd :
							((op == `OP_LOAD) ? instr.r.rs1 :
							((op == `OP_RET) ? '0 : instr.r.rs2));

	// Zero, negative and overflow share one enable
	assign flagEn		= !((op == `OP_LHW) || (op == `OP_LLW) || (op == `OP_FLUSH) ||
							(op == `OP_BRANCH) || isLink || isMem || (op == `OP_HALT) ||
							(op == `OP_ENQC) || (op == `OP_ENQD) || (op == `OP_DEQD));

	assign memToReg		= (op == `OP_LOAD);
	assign memValid		= isMem || isLink;
	assign memWrite		= (op == `OP_STORE) || (op == `OP_CALL);

	assign exu			= isFpu ? decodePkg::EXU_FPU :
							(isMdu ? decodePkg::EXU_MDU : decodePkg::EXU_ALU);
	assign aluOp		= (isMem || isLink) ? `ALU_ADD : op[3:0];
	assign fpuOp		= op[2:0];
	assign mduOp		= op[0];
	assign shiftAmt		= isShift ? instr.r.shamt : '0;

	// Branch view
	assign branchOp		= decodePkg::branchCond'(instr.b.cond);
	assign offset		= {instr.b.cond, instr.b.offsetLow};

	assign branchCmd	= (op == `OP_BRANCH);
	assign jumpCmd		= (op == `OP_CALL);
	assign callCmd		= (op == `OP_CALL);
	assign retCmd		= (op == `OP_RET);
	assign loadCmd		= (op == `OP_LHW);
	assign storeCmd		= (op == `OP_STORE);
	assign aluCmd		= (op == `OP_LHW) || (op == `OP_LLW) || isMem;
	assign cacheFlush	= (op == `OP_FLUSH);
	assign halt			= (op == `OP_HALT);
	assign npuCfg		= (op == `OP_ENQC);
	assign npuEnq		= (op == `OP_ENQD);
	assign npuDeq		= (op == `OP_DEQD);

endmodule

/* hw/regFile.sv */
// Register file
`timescale 1ns/1ns
`include "decode_consts.svh"

module regFile (
	input	logic						clk,
	input	logic [`REG_ADDR_W-1:0]		readAddr0,
	input	logic						readEn0,
	input	logic [`REG_ADDR_W-1:0]		readAddr1,
	input	logic						readEn1,
	input	logic						wbEn,
	input	logic [`REG_ADDR_W-1:0]		wbAddr,
	input	logic [`DATA_W-1:0]			wbData,
	output	logic [`DATA_W-1:0]			readData0,
	output	logic [`DATA_W-1:0]			readData1
);

	logic [`DATA_W-1:0]	regs [`REG_COUNT];

	// Write-first read with register zero hardwired
	function automatic logic [`DATA_W-1:0] readPort(
		input logic						en,
		input logic [`REG_ADDR_W-1:0]	addr
	);
		if (!en || addr == '0)
			return '0;
		else if (wbEn && wbAddr == addr)
			return wbData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wbEn && wbAddr != '0)
			regs[wbAddr] <= wbData;
	end

	always_comb begin
		readData0 = readPort(readEn0, readAddr0);
		readData1 = readPort(readEn1, readAddr1);
	end

endmodule

/* hw/issueRegister.sv */
// Issue register
`timescale 1ns/1ns
`include "decode_consts.svh"

module issueRegister (
	input	logic						clk,
	input	logic						arstN,
	input	logic						instValid,
	input	logic [`DATA_W-1:0]			readData0,
	input	logic [`DATA_W-1:0]			readData1,
	input	logic [`REG_ADDR_W-1:0]		decWriteAddr,
	input	logic						decWriteEn,
	input	decodePkg::exuSel			decExu,
	input	logic [3:0]					decAluOp,
	input	logic [2:0]					decFpuOp,
	input	logic						decMduOp,
	input	decodePkg::branchCond		decBranchOp,
	input	logic [`SHIFT_W-1:0]		decShiftAmt,
	input	logic [`OFFSET_W-1:0]		decOffset,
	input	logic						decMemValid,
	input	logic						decMemWrite,
	input	logic						decMemToReg,
	input	logic						decFlagEn,
	input	logic						decBranchCmd,
	input	logic						decJumpCmd,
	input	logic						decCallCmd,
	input	logic						decRetCmd,
	input	logic						decLoadCmd,
	input	logic						decStoreCmd,
	input	logic						decAluCmd,
	input	logic						decCacheFlush,
	input	logic						decHalt,
	input	logic						decNpuCfg,
	input	logic						decNpuEnq,
	input	logic						decNpuDeq,
	output	logic						issueValid,
	output	logic [`DATA_W-1:0]			operandA,
	output	logic [`DATA_W-1:0]			operandB,
	output	logic [`REG_ADDR_W-1:0]		writeAddr,
	output	logic						writeEn,
	output	decodePkg::exuSel			exu,
	output	logic [3:0]					aluOp,
	output	logic [2:0]					fpuOp,
	output	logic						mduOp,
	output	decodePkg::branchCond		branchOp,
	output	logic [`SHIFT_W-1:0]		shiftAmt,
	output	logic [`OFFSET_W-1:0]		offset,
	output	logic						memValid,
	output	logic						memWrite,
	output	logic						memToReg,
	output	logic						flagEn,
	output	logic						branchCmd,
	output	logic						jumpCmd,
	output	logic						callCmd,
	output	logic						retCmd,
	output	logic						loadCmd,
	output	logic						storeCmd,
	output	logic						aluCmd,
	output	logic						cacheFlush,
	output	logic						halt,
	output	logic						npuCfg,
	output	logic						npuEnq,
	output	logic						npuDeq
);

	localparam int CTRL_W = 16;

	logic [CTRL_W-1:0]	ctrlD;
	logic [CTRL_W-1:0]	ctrlQ;

	assign ctrlD = {decWriteEn, decMemValid, decMemWrite, decFlagEn,
					decBranchCmd, decJumpCmd, decCallCmd, decRetCmd,
					decLoadCmd, decStoreCmd, decAluCmd, decCacheFlush,
					decHalt, decNpuCfg, decNpuEnq, decNpuDeq};

	assign {writeEn, memValid, memWrite, flagEn,
			branchCmd, jumpCmd, callCmd, retCmd,
			loadCmd, storeCmd, aluCmd, cacheFlush,
			halt, npuCfg, npuEnq, npuDeq} = ctrlQ;

	// Control bits pulse with issueValid only
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			issueValid	<= 1'b0;
			ctrlQ		<= '0;
		end else begin
			issueValid	<= instValid;
			ctrlQ		<= instValid ? ctrlD : '0;
		end
	end

	// Payload holds between strobes
	always_ff @(posedge clk) begin
		if (instValid) begin
			operandA	<= readData0;
			operandB	<= readData1;
			writeAddr	<= decWriteAddr;
			exu			<= decExu;
			aluOp		<= decAluOp;
			fpuOp		<= decFpuOp;
			mduOp		<= decMduOp;
			branchOp	<= decBranchOp;
			shiftAmt	<= decShiftAmt;
			offset		<= decOffset;
			memToReg	<= decMemToReg;
		end
	end

endmodule

/* hw/decodeUnit.sv */
// Decode stage top level
`timescale 1ns/1ns
`include "decode_consts.svh"

module decodeUnit (
	input	logic						clk,
	input	logic						arstN,
	input	logic						instValid,
	input	decodePkg::instrWord		instr,
	input	logic						wbEn,
	input	logic [`REG_ADDR_W-1:0]		wbAddr,
	input	logic [`DATA_W-1:0]			wbData,
	output	logic						issueValid,
	output	logic [`DATA_W-1:0]			operandA,
	output	logic [`DATA_W-1:0]			operandB,
	output	logic [`REG_ADDR_W-1:0]		writeAddr,
	output	logic						writeEn,
	output	decodePkg::exuSel			exu,
	output	logic [3:0]					aluOp,
	output	logic [2:0]					fpuOp,
	output	logic						mduOp,
	output	decodePkg::branchCond		branchOp,
	output	logic [`SHIFT_W-1:0]		shiftAmt,
	output	logic [`OFFSET_W-1:0]		offset,
	output	logic						memValid,
	output	logic						memWrite,
	output	logic						memToReg,
	output	logic						flagEn,
	output	logic						branchCmd,
	output	logic						jumpCmd,
	output	logic						callCmd,
	output	logic						retCmd,
	output	logic						loadCmd,
	output	logic						storeCmd,
	output	logic						aluCmd,
	output	logic						cacheFlush,
	output	logic						halt,
	output	logic						npuCfg,
	output	logic						npuEnq,
	output	logic						npuDeq
);

	logic [`REG_ADDR_W-1:0]	readAddr0;
	logic [`REG_ADDR_W-1:0]	readAddr1;
	logic					readEn0;
	logic					readEn1;
	logic [`DATA_W-1:0]		readData0;
	logic [`DATA_W-1:0]		readData1;

	// Decoded bundle before the issue register
	logic [`REG_ADDR_W-1:0]	decWriteAddr;
	logic					decWriteEn;
	decodePkg::exuSel		decExu;
	logic [3:0]				decAluOp;
	logic [2:0]				decFpuOp;
	logic					decMduOp;
	decodePkg::branchCond	decBranchOp;
	logic [`SHIFT_W-1:0]	decShiftAmt;
	logic [`OFFSET_W-1:0]	decOffset;
	logic					decMemValid;
	logic					decMemWrite;
	logic					decMemToReg;
	logic					decFlagEn;
	logic					decBranchCmd;
	logic					decJumpCmd;
	logic					decCallCmd;
	logic					decRetCmd;
	logic					decLoadCmd;
	logic					decStoreCmd;
	logic					decAluCmd;
	logic					decCacheFlush;
	logic					decHalt;
	logic					decNpuCfg;
	logic					decNpuEnq;
	logic					decNpuDeq;

	instrDecoder decoder (
		.instr		(instr),
		.readAddr0	(readAddr0),
		.readEn0	(readEn0),
		.readAddr1	(readAddr1),
		.readEn1	(readEn1),
		.writeAddr	(decWriteAddr),
		.writeEn	(decWriteEn),
		.exu		(decExu),
		.aluOp		(decAluOp),
		.fpuOp		(decFpuOp),
		.mduOp		(decMduOp),
		.branchOp	(decBranchOp),
		.shiftAmt	(decShiftAmt),
		.offset		(decOffset),
		.memValid	(decMemValid),
		.memWrite	(decMemWrite),
		.memToReg	(decMemToReg),
		.flagEn		(decFlagEn),
		.branchCmd	(decBranchCmd),
		.jumpCmd	(decJumpCmd),
		.callCmd	(decCallCmd),
		.retCmd		(decRetCmd),
		.loadCmd	(decLoadCmd),
		.storeCmd	(decStoreCmd),
		.aluCmd		(decAluCmd),
		.cacheFlush	(decCacheFlush),
		.halt		(decHalt),
		.npuCfg		(decNpuCfg),
		.npuEnq		(decNpuEnq),
		.npuDeq		(decNpuDeq)
	);

	// Port names match the local nets
	regFile regs (.*);

	issueRegister issue (.*);

endmodule

/* dv/decodeUnit_assert.sv */
// Issue register assertions
`timescale 1ns/1ns

module decodeUnit_assert (
	input	logic	clk,
	input	logic	arstN,
	input	logic	writeEn,
	input	logic	branchCmd,
	input	logic	callCmd,
	input	logic	retCmd,
	input	logic	storeCmd,
	input	logic	halt
);

	// Link instructions always write the link register
	linkWritesBack: assert property (
		@(posedge clk) disable iff (!arstN) (callCmd || retCmd) |-> writeEn
	) else $error("call or ret issued without writeEn");

	// Control transfers never combine
	exclusiveCommands: assert property (
		@(posedge clk) disable iff (!arstN) $onehot0({callCmd, retCmd, branchCmd, halt})
	) else $error("more than one of call, ret, branch and halt issued together");

	noWriteOnStoreOrBranch: assert property (
		@(posedge clk) disable iff (!arstN) (storeCmd || branchCmd) |-> !writeEn
	) else $error("writeEn high with a store or branch");

endmodule

bind issueRegister decodeUnit_assert checks (.*);

/* dv/decodeTb.sv */
// Decode stage testbench
`timescale 1ns/1ns
`include "decode_consts.svh"

module decodeTb;

	localparam int ISSUE_TIMEOUT = 5;

	logic						clk;
	logic						arstN;
	logic						instValid;
	decodePkg::instrWord		instr;
	logic						wbEn;
	logic [`REG_ADDR_W-1:0]		wbAddr;
	logic [`DATA_W-1:0]			wbData;
	logic						issueValid;
	logic [`DATA_W-1:0]			operandA;
	logic [`DATA_W-1:0]			operandB;
	logic [`REG_ADDR_W-1:0]		writeAddr;
	logic						writeEn;
	decodePkg::exuSel			exu;
	logic [3:0]					aluOp;
	logic [2:0]					fpuOp;
	logic						mduOp;
	decodePkg::branchCond		branchOp;
	logic [`SHIFT_W-1:0]		shiftAmt;
	logic [`OFFSET_W-1:0]		offset;
	logic						memValid;
	logic						memWrite;
	logic						memToReg;
	logic						flagEn;
	logic						branchCmd;
	logic						jumpCmd;
	logic						callCmd;
	logic						retCmd;
	logic						loadCmd;
	logic						storeCmd;
	logic						aluCmd;
	logic						cacheFlush;
	logic						halt;
	logic						npuCfg;
	logic						npuEnq;
	logic						npuDeq;
	int							vecNum;

	decodeUnit DUT (.*);

	always #10 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s vector %0d expected %h actual %h", name, vecNum, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic driveRow(input logic [31:0] rowWbEn, input logic [31:0] rowWbAddr,
			input logic [31:0] rowWbData, input logic [31:0] rowValid,
			input logic [31:0] rowInstr);
		wbEn		= rowWbEn[0];
		wbAddr		= rowWbAddr[`REG_ADDR_W-1:0];
		wbData		= rowWbData;
		instValid	= rowValid[0];
		instr		= decodePkg::instrWord'(rowInstr);
	endtask

	// Valid and command bits only, memToReg belongs to the held payload
	task automatic checkQuiet();
		logic [15:0] ctrl;
		ctrl = {writeEn, memValid, memWrite, flagEn, branchCmd, jumpCmd, callCmd, retCmd,
				loadCmd, storeCmd, aluCmd, cacheFlush, halt, npuCfg, npuEnq, npuDeq};
		checkValue("issueValid", '0, 32'(issueValid));
		checkValue("commands", '0, 32'(ctrl));
	endtask

	task automatic waitForIssue();
		int cycles;
		@(negedge clk);
		cycles = 1;
		while (!issueValid) begin
			if (cycles >= ISSUE_TIMEOUT) begin
				$display("Timed out waiting for issueValid after an instruction strobe");
				$display("Simulation failed");
				$fatal(1);
			end
			// Stop a repeated strobe while waiting
			instValid = 1'b0;
			@(negedge clk);
			cycles++;
		end
		checkValue("issue latency", 32'd1, 32'(cycles));
	endtask

	task automatic checkIssued(input logic [31:0] rawInstr, input logic [31:0] expA,
			input logic [31:0] expB, input logic [31:0] expWA, input logic [31:0] expExu,
			input logic [31:0] expAluOp, input logic [31:0] expFpuOp,
			input logic [31:0] expMduOp, input logic [31:0] expCmd);
		logic [5:0]		op;
		logic [31:0]	expShift;
		logic [16:0]	ctrl;
		op = rawInstr[31:26];
		// Shift amount only survives for shifts
		if (op == `OP_SLL || op == `OP_SRL || op == `OP_SRA)
			expShift = 32'(rawInstr[4:0]);
		else
			expShift = '0;
		ctrl = {writeEn, memValid, memWrite, memToReg, flagEn, branchCmd, jumpCmd, callCmd,
				retCmd, loadCmd, storeCmd, aluCmd, cacheFlush, halt, npuCfg, npuEnq, npuDeq};
		checkValue("operandA", expA, operandA);
		checkValue("operandB", expB, operandB);
		checkValue("writeAddr", expWA, 32'(writeAddr));
		checkValue("exu", expExu, 32'(exu));
		checkValue("aluOp", expAluOp, 32'(aluOp));
		checkValue("fpuOp", expFpuOp, 32'(fpuOp));
		checkValue("mduOp", expMduOp, 32'(mduOp));
		checkValue("branchOp", 32'(expCmd[19:17]), 32'(branchOp));
		checkValue("commands", 32'(expCmd[16:0]), 32'(ctrl));
		checkValue("shiftAmt", expShift, 32'(shiftAmt));
		checkValue("offset", 32'(rawInstr[25:0]), 32'(offset));
	endtask

	initial begin
		int				fd;
		int				count;
		string			line;
		logic [31:0]	rowWbEn;
		logic [31:0]	rowWbAddr;
		logic [31:0]	rowWbData;
		logic [31:0]	rowValid;
		logic [31:0]	rowInstr;
		logic [31:0]	expA;
		logic [31:0]	expB;
		logic [31:0]	expWA;
		logic [31:0]	expExu;
		logic [31:0]	expAluOp;
		logic [31:0]	expFpuOp;
		logic [31:0]	expMduOp;
		logic [31:0]	expCmd;

		clk			= 1'b0;
		arstN		= 1'b0;
		instValid	= 1'b0;
		instr		= '0;
		wbEn		= 1'b0;
		wbAddr		= '0;
		wbData		= '0;
		vecNum		= 0;

		fd = $fopen("dv/decode_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file dv/decode_stimulus.txt");
			$display("Simulation failed");
			$fatal(1);
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkQuiet();

		// Each row is driven on the falling edge that checked the previous one
		while (!$feof(fd)) begin
			line = "";
			count = $fgets(line, fd);
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
					rowWbEn, rowWbAddr, rowWbData, rowValid, rowInstr, expA, expB, expWA,
					expExu, expAluOp, expFpuOp, expMduOp, expCmd);
			if (count != 13) begin
				$display("Malformed stimulus line after vector %0d", vecNum);
				$display("Simulation failed");
				$fatal(1);
			end
			vecNum++;
			driveRow(rowWbEn, rowWbAddr, rowWbData, rowValid, rowInstr);
			if (rowValid[0]) begin
				waitForIssue();
				checkIssued(rowInstr, expA, expB, expWA, expExu, expAluOp, expFpuOp,
						expMduOp, expCmd);
			end else begin
				@(negedge clk);
				checkQuiet();
			end
		end
		$fclose(fd);
		driveRow('0, '0, '0, '0, '0);

		if (vecNum == 0) begin
			$display("The stimulus file held no vectors");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* vlog.f */
+incdir+include
hw/decodePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/issueRegister.sv
hw/decodeUnit.sv
dv/decodeUnit_assert.sv
dv/decodeTb.sv

/* Makefile */
TOP := decodeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o simv

run: compile
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* dv/decode_stimulus.txt */
# wbEn wbAddr wbData instValid instr | operandA operandB writeAddr exu aluOp fpuOp mduOp cmd
# cmd = {branchOp[2:0], writeEn, memValid, memWrite, memToReg, flagEn, branch, jump, call, ret, load, store, alu, flush, halt, npuCfg, npuEnq, npuDeq}
1 01 00001000 0 00000000 00000000 00000000 00 0 0 0 0 00000
1 02 00000002 0 00000000 00000000 00000000 00 0 0 0 0 00000
1 03 80000003 0 00000000 00000000 00000000 00 0 0 0 0 00000
1 04 12345678 0 00000000 00000000 00000000 00 0 0 0 0 00000
1 05 0000abcd 0 00000000 00000000 00000000 00 0 0 0 0 00000
0 00 00000000 1 00c21800 00000002 80000003 06 0 0 0 0 31000
0 00 00000000 1 04e42800 12345678 0000abcd 07 0 1 1 1 31000
0 00 00000000 1 21020004 00000002 00000000 08 0 8 0 0 51000
0 00 00000000 1 2923001f 80000003 00000000 09 0 a 2 0 51000
0 00 00000000 1 19441007 12345678 00000002 0a 0 6 6 0 51000
1 0b cafef00d 1 018b0000 cafef00d 00000000 0c 0 0 0 0 71000
1 00 ffffffff 1 15a05800 00000000 cafef00d 0d 0 5 5 1 71000
0 00 00000000 1 1dc42800 12345678 00000000 0e 0 7 7 1 71000
0 00 00000000 1 40812345 00000000 00000000 04 0 0 0 0 20800
0 00 00000000 1 43ffffff 00000000 00000000 1f 0 0 0 0 e0800
0 00 00000000 1 44001000 00001000 00000000 01 0 0 1 1 1c600
0 00 00000000 1 48001800 00001000 00000000 01 0 0 2 0 18100
0 00 00000000 1 51e42800 12345678 12345678 0f 0 0 4 0 7a020
0 00 00000000 1 54a21800 00000002 0000abcd 05 0 0 5 1 2c060
0 00 00000000 1 5a022000 00000002 12345678 10 1 6 6 0 91000
0 00 00000000 1 5e241000 12345678 00000002 11 1 7 7 1 91000
0 00 00000000 1 62432800 80000003 0000abcd 12 2 8 0 0 91000
0 00 00000000 1 7a641800 12345678 00000000 13 2 e 6 0 91000
0 00 00000000 1 80000000 00000000 00000000 00 0 0 0 0 00004
0 00 00000000 1 90800000 12345678 00000000 04 0 4 4 0 20002
0 00 00000000 1 96800000 00000000 00000000 14 0 5 5 1 b0001
0 00 00000000 1 30000000 00000000 00000000 00 0 c 4 0 00010
0 00 00000000 1 7c000000 00000000 00000000 00 0 f 7 1 00008
0 00 00000000 0 00000000 00000000 00000000 00 0 0 0 0 00000
